// File: hw/wfd_pkg.sv
// waveform digitizer readout definitions
package wfd_pkg;

    // board geometry
    localparam int num_chan = 2;                    // channel FPGAs on the board
    localparam int chan_idx_w = $clog2(num_chan);   // bits to name one channel

    // datapath widths
    localparam int fill_w = 24;         // fill number
    localparam int chan_data_w = 32;    // one word from a channel link
    localparam int daq_w = 64;          // one word toward the DAQ link
    localparam int word_count_w = 20;   // frame length field of the trailer
    localparam int tag_w = 8;           // type tag in the top byte of a DAQ word

    // fill number queue
    localparam int fill_fifo_depth = 4;
    localparam int fifo_ptr_w = $clog2(fill_fifo_depth);
    localparam int fifo_count_w = $clog2(fill_fifo_depth + 1); // must reach full depth

    typedef logic [fill_w-1:0]       fill_num_t;
    typedef logic [chan_data_w-1:0]  chan_data_t;
    typedef logic [chan_idx_w-1:0]   chan_idx_t;
    typedef logic [num_chan-1:0]     chan_mask_t;
    typedef logic [daq_w-1:0]        daq_word_t;
    typedef logic [word_count_w-1:0] word_count_t;
    typedef logic [tag_w-1:0]        daq_tag_t;
    typedef logic [fifo_ptr_w-1:0]   fifo_ptr_t;
    typedef logic [fifo_count_w-1:0] fifo_count_t;

    // tags in bits 63:56 of every DAQ word
    localparam daq_tag_t header_tag = 8'hA5;
    localparam daq_tag_t payload_tag = 8'h5A;
    localparam daq_tag_t trailer_tag = 8'hC3;

    // trigger manager states
    typedef enum logic [1:0] {
        tm_idle,        // waiting for a trigger
        tm_arm,         // pulse the channels and push the fill number
        tm_wait_done    // collecting done flags
    } tm_state_t;

    // data transfer manager states
    typedef enum logic [1:0] {
        dtm_idle,       // waiting for a fill number
        dtm_header,     // header word pending
        dtm_payload,    // passing channel packets through
        dtm_trailer     // trailer word pending
    } dtm_state_t;

endpackage

// File: hw/trigger_manager.sv
// acquisition trigger manager
`timescale 1ns/100ps

module trigger_manager (
    input  logic                clk125,
    input  logic                reset,
    input  logic                trigger,        // trigger request
    input  wfd_pkg::chan_mask_t chan_done,      // done flag per channel
    input  logic                fifo_tready,    // fill queue has room
    output wfd_pkg::chan_mask_t acq_trigs,      // one cycle acquisition pulse
    output logic                fifo_tvalid,    // push the new fill number
    output wfd_pkg::fill_num_t  fifo_tdata
);

    wfd_pkg::tm_state_t  state;
    wfd_pkg::fill_num_t  fill_cnt;    // number of the next accepted fill
    wfd_pkg::chan_mask_t done_seen;   // sticky done per channel
    logic                accept;

    // a trigger counts only when idle and the queue can take its number
    assign accept = trigger && fifo_tready && (state == wfd_pkg::tm_idle);

    always_ff @(posedge clk125) begin
        if (reset) begin
            state <= wfd_pkg::tm_idle;
            fill_cnt <= wfd_pkg::fill_num_t'(1);    // fills count from 1
            done_seen <= '0;
        end else begin
            case (state)
                wfd_pkg::tm_idle: begin
                    if (accept) begin
                        state <= wfd_pkg::tm_arm;
                        done_seen <= '0;            // fresh mask for this fill
                    end
                end
                wfd_pkg::tm_arm: begin
                    // pulse and push happen in this cycle, number is used up
                    state <= wfd_pkg::tm_wait_done;
                    fill_cnt <= fill_cnt + 1'b1;
                end
                wfd_pkg::tm_wait_done: begin
                    done_seen <= done_seen | chan_done;
                    // every channel has reported at least once
                    if (done_seen == '1) begin
                        state <= wfd_pkg::tm_idle;
                    end
                end
                default: begin
                    state <= wfd_pkg::tm_idle;
                end
            endcase
        end
    end

    // all channels start together
    assign acq_trigs = {wfd_pkg::num_chan{state == wfd_pkg::tm_arm}};

    // fifo_tready was high on accept and only our own push can fill the
    // queue, so this single cycle write always lands
    assign fifo_tvalid = (state == wfd_pkg::tm_arm);
    assign fifo_tdata = fill_cnt;

endmodule

// File: hw/fill_num_fifo.sv
// fill number queue
`timescale 1ns/100ps

module fill_num_fifo (
    input  logic               clk125,
    input  logic               reset,
    input  logic               s_tvalid,   // write side
    input  wfd_pkg::fill_num_t s_tdata,
    output logic               s_tready,
    output logic               m_tvalid,   // read side
    input  logic               m_tready,
    output wfd_pkg::fill_num_t m_tdata
);

    wfd_pkg::fill_num_t  mem [wfd_pkg::fill_fifo_depth];
    wfd_pkg::fifo_ptr_t  wr_ptr;
    wfd_pkg::fifo_ptr_t  rd_ptr;
    wfd_pkg::fifo_count_t count;    // entries held
    logic                wr_en;
    logic                rd_en;

    assign wr_en = s_tvalid && s_tready;
    assign rd_en = m_tvalid && m_tready;

    // storage
    always_ff @(posedge clk125) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_tdata;
        end
    end

    always_ff @(posedge clk125) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                // wrap at the last slot
                wr_ptr <= (wr_ptr == wfd_pkg::fifo_ptr_t'(wfd_pkg::fill_fifo_depth - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == wfd_pkg::fifo_ptr_t'(wfd_pkg::fill_fifo_depth - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign s_tready = (count != wfd_pkg::fifo_count_t'(wfd_pkg::fill_fifo_depth)); // full stops writes
    assign m_tvalid = (count != '0);    // a write shows up here one cycle later
    assign m_tdata = mem[rd_ptr];       // head of the queue

endmodule

// File: hw/channel_rx_switch.sv
// channel packet receive switch
`timescale 1ns/100ps

module channel_rx_switch (
    input  logic                clk125,
    input  logic                reset,
    // channel 0 stream
    input  logic                c0_tvalid,
    input  logic                c0_tlast,
    input  wfd_pkg::chan_data_t c0_tdata,
    output logic                c0_tready,
    // channel 1 stream
    input  logic                c1_tvalid,
    input  logic                c1_tlast,
    input  wfd_pkg::chan_data_t c1_tdata,
    output logic                c1_tready,
    // merged stream toward the data transfer manager
    output logic                rx_tvalid,
    output logic                rx_tlast,
    output wfd_pkg::chan_data_t rx_tdata,
    output wfd_pkg::chan_idx_t  rx_chan,    // channel owning the grant
    input  logic                rx_tready
);

    wfd_pkg::chan_idx_t turn;   // granted channel
    logic               pkt_end;

    // a packet is over once its last word has moved
    assign pkt_end = rx_tvalid && rx_tready && rx_tlast;

    always_ff @(posedge clk125) begin
        if (reset) begin
            turn <= '0;     // channel 0 goes first
        end else if (pkt_end) begin
            turn <= (turn == wfd_pkg::chan_idx_t'(wfd_pkg::num_chan - 1)) ?
                    '0 : turn + 1'b1;
        end
    end

    // combinational steering, no register in the data path
    always_comb begin
        case (turn)
            1'b0: begin
                rx_tvalid = c0_tvalid;
                rx_tlast = c0_tlast;
                rx_tdata = c0_tdata;
            end
            default: begin
                rx_tvalid = c1_tvalid;
                rx_tlast = c1_tlast;
                rx_tdata = c1_tdata;
            end
        endcase
    end

    // only the granted channel sees ready, the other one waits
    assign c0_tready = (turn == 1'b0) && rx_tready;
    assign c1_tready = (turn == 1'b1) && rx_tready;

    assign rx_chan = turn;

endmodule

// File: hw/data_transfer_manager.sv
// DAQ event frame builder
`timescale 1ns/100ps

module data_transfer_manager (
    input  logic                 clk125,
    input  logic                 reset,
    // fill number queue
    input  logic                 fill_tvalid,
    input  wfd_pkg::fill_num_t   fill_tdata,
    output logic                 fill_tready,
    // merged channel stream
    input  logic                 rx_tvalid,
    input  logic                 rx_tlast,
    input  wfd_pkg::chan_data_t  rx_tdata,
    input  wfd_pkg::chan_idx_t   rx_chan,
    output logic                 rx_tready,
    // DAQ link
    output logic                 daq_valid,
    input  logic                 daq_ready,
    output logic                 daq_header,
    output logic                 daq_trailer,
    output wfd_pkg::daq_word_t   daq_data
);

    wfd_pkg::dtm_state_t  state;
    wfd_pkg::fill_num_t   fill_reg;     // fill being framed
    wfd_pkg::word_count_t word_cnt;     // words sent so far in this frame
    wfd_pkg::chan_idx_t   pkt_cnt;      // packets finished so far
    wfd_pkg::daq_word_t   next_word;
    logic                 out_free;     // output register can take a word
    logic                 fill_pop;
    logic                 load_hdr;
    logic                 load_pay;
    logic                 load_trl;
    logic                 last_pkt;

    assign out_free = !daq_valid || daq_ready;
    assign fill_tready = (state == wfd_pkg::dtm_idle);
    assign fill_pop = fill_tvalid && fill_tready;

    // hold the channel stream while a word waits at the output
    assign rx_tready = (state == wfd_pkg::dtm_payload) && out_free;

    assign load_hdr = (state == wfd_pkg::dtm_header) && out_free;
    assign load_pay = rx_tvalid && rx_tready;
    assign load_trl = (state == wfd_pkg::dtm_trailer) && out_free;
    assign last_pkt = rx_tlast && (pkt_cnt == wfd_pkg::chan_idx_t'(wfd_pkg::num_chan - 1));

    // word formats
    always_comb begin
        next_word = '0;
        if (load_hdr) begin
            next_word[63:56] = wfd_pkg::header_tag;
            next_word[wfd_pkg::fill_w-1:0] = fill_reg;      // zero padded above
        end else if (load_pay) begin
            next_word[63:56] = wfd_pkg::payload_tag;
            next_word[55:48] = 8'(rx_chan);                 // source channel
            next_word[31:0] = rx_tdata;
        end else begin
            next_word[63:56] = wfd_pkg::trailer_tag;
            next_word[wfd_pkg::word_count_w-1:0] = word_cnt + 1'b1; // trailer counts itself
        end
    end

    always_ff @(posedge clk125) begin
        if (reset) begin
            state <= wfd_pkg::dtm_idle;
            word_cnt <= '0;
            pkt_cnt <= '0;
        end else begin
            case (state)
                wfd_pkg::dtm_idle: begin
                    if (fill_pop) begin
                        state <= wfd_pkg::dtm_header;
                    end
                end
                wfd_pkg::dtm_header: begin
                    if (load_hdr) begin
                        word_cnt <= wfd_pkg::word_count_t'(1);  // header is word one
                        pkt_cnt <= '0;
                        state <= wfd_pkg::dtm_payload;
                    end
                end
                wfd_pkg::dtm_payload: begin
                    if (load_pay) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (rx_tlast) begin
                            pkt_cnt <= pkt_cnt + 1'b1;
                        end
                        if (last_pkt) begin
                            state <= wfd_pkg::dtm_trailer;  // every channel is in
                        end
                    end
                end
                wfd_pkg::dtm_trailer: begin
                    if (load_trl) begin
                        state <= wfd_pkg::dtm_idle;
                    end
                end
                default: begin
                    state <= wfd_pkg::dtm_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk125) begin
        if (fill_pop) begin
            fill_reg <= fill_tdata;
        end
    end

    // output register flags
    always_ff @(posedge clk125) begin
        if (reset) begin
            daq_valid <= 1'b0;
            daq_header <= 1'b0;
            daq_trailer <= 1'b0;
        end else if (load_hdr || load_pay || load_trl) begin
            daq_valid <= 1'b1;
            daq_header <= load_hdr;
            daq_trailer <= load_trl;
        end else if (daq_ready) begin
            daq_valid <= 1'b0;      // word taken, nothing new
            daq_header <= 1'b0;
            daq_trailer <= 1'b0;
        end
    end

    always_ff @(posedge clk125) begin
        if (load_hdr || load_pay || load_trl) begin
            daq_data <= next_word;  // stable while daq_ready is low
        end
    end

endmodule

// File: hw/wfd_readout_top.sv
// digitizer master readout path
`timescale 1ns/100ps

module wfd_readout_top (
    input  logic                clk125,
    input  logic                reset,
    input  logic                trigger,        // trigger request
    output wfd_pkg::chan_mask_t acq_trigs,      // acquisition pulse per channel
    input  wfd_pkg::chan_mask_t chan_done,      // done flag per channel
    // channel 0 stream
    input  logic                c0_tvalid,
    output logic                c0_tready,
    input  logic                c0_tlast,
    input  wfd_pkg::chan_data_t c0_tdata,
    // channel 1 stream
    input  logic                c1_tvalid,
    output logic                c1_tready,
    input  logic                c1_tlast,
    input  wfd_pkg::chan_data_t c1_tdata,
    // DAQ link
    output logic                daq_valid,
    input  logic                daq_ready,
    output logic                daq_header,
    output logic                daq_trailer,
    output wfd_pkg::daq_word_t  daq_data
);

    // trigger manager to fill queue
    logic                fifo_tvalid;
    logic                fifo_tready;
    wfd_pkg::fill_num_t  fifo_tdata;

    // fill queue to data transfer manager
    logic                fill_tvalid;
    logic                fill_tready;
    wfd_pkg::fill_num_t  fill_tdata;

    // switch to data transfer manager
    logic                rx_tvalid;
    logic                rx_tready;
    logic                rx_tlast;
    wfd_pkg::chan_data_t rx_tdata;
    wfd_pkg::chan_idx_t  rx_chan;

    trigger_manager tm (
        .clk125      (clk125),
        .reset       (reset),
        .trigger     (trigger),
        .chan_done   (chan_done),
        .fifo_tready (fifo_tready),
        .acq_trigs   (acq_trigs),
        .fifo_tvalid (fifo_tvalid),
        .fifo_tdata  (fifo_tdata)
    );

    fill_num_fifo fill_fifo (
        .clk125   (clk125),
        .reset    (reset),
        .s_tvalid (fifo_tvalid),
        .s_tdata  (fifo_tdata),
        .s_tready (fifo_tready),
        .m_tvalid (fill_tvalid),
        .m_tready (fill_tready),
        .m_tdata  (fill_tdata)
    );

    channel_rx_switch rx_switch (
        .clk125    (clk125),
        .reset     (reset),
        .c0_tvalid (c0_tvalid),
        .c0_tlast  (c0_tlast),
        .c0_tdata  (c0_tdata),
        .c0_tready (c0_tready),
        .c1_tvalid (c1_tvalid),
        .c1_tlast  (c1_tlast),
        .c1_tdata  (c1_tdata),
        .c1_tready (c1_tready),
        .rx_tvalid (rx_tvalid),
        .rx_tlast  (rx_tlast),
        .rx_tdata  (rx_tdata),
        .rx_chan   (rx_chan),
        .rx_tready (rx_tready)
    );

    data_transfer_manager dtm (
        .clk125      (clk125),
        .reset       (reset),
        .fill_tvalid (fill_tvalid),
        .fill_tdata  (fill_tdata),
        .fill_tready (fill_tready),
        .rx_tvalid   (rx_tvalid),
        .rx_tlast    (rx_tlast),
        .rx_tdata    (rx_tdata),
        .rx_chan     (rx_chan),
        .rx_tready   (rx_tready),
        .daq_valid   (daq_valid),
        .daq_ready   (daq_ready),
        .daq_header  (daq_header),
        .daq_trailer (daq_trailer),
        .daq_data    (daq_data)
    );

endmodule

// File: tests/tb_wfd_readout.sv
// digitizer readout testbench
`timescale 1ns/100ps

module tb_wfd_readout;

    logic        clk125;
    logic        reset = 1'b1;
    logic        trigger = 1'b0;
    logic [1:0]  acq_trigs;
    logic [1:0]  chan_done = 2'b00;
    logic [1:0]  ch_tvalid = 2'b00;
    logic [1:0]  ch_tready;
    logic [1:0]  ch_tlast = 2'b00;
    logic [31:0] ch_tdata [2] = '{default: '0};
    logic        daq_valid;
    logic        daq_ready = 1'b0;
    logic        daq_header;
    logic        daq_trailer;
    logic [63:0] daq_data;

    // one ring of {tlast, data} words per channel model
    logic [32:0] words [2][256];
    int          wr_idx [2];
    int          rel_idx [2];           // end of the words released by done
    int          rd_idx [2];
    int          done_wait [2];         // cycles left until done rises
    logic [65:0] exp_q [$];             // expected word with its kind above (1 header, 2 trailer)
    int          fills_seen = 0;
    int          open_cnt = 0;
    int          frames_open = 0;       // frames still owed by the DUT
    int          errors = 0;
    int          checks = 0;
    int          tests_done = 0;
    int          accepts_expected = 0;
    int          cyc = 0;
    int          seed_val;
    logic        stall = 1'b0;          // sink holds daq_ready low

    wfd_readout_top u_dut (
        .clk125      (clk125),
        .reset       (reset),
        .trigger     (trigger),
        .acq_trigs   (acq_trigs),
        .chan_done   (chan_done),
        .c0_tvalid   (ch_tvalid[0]),
        .c0_tready   (ch_tready[0]),
        .c0_tlast    (ch_tlast[0]),
        .c0_tdata    (ch_tdata[0]),
        .c1_tvalid   (ch_tvalid[1]),
        .c1_tready   (ch_tready[1]),
        .c1_tlast    (ch_tlast[1]),
        .c1_tdata    (ch_tdata[1]),
        .daq_valid   (daq_valid),
        .daq_ready   (daq_ready),
        .daq_header  (daq_header),
        .daq_trailer (daq_trailer),
        .daq_data    (daq_data)
    );

    initial begin
        clk125 = 1'b0;
        forever #50 clk125 = ~clk125;   // 100 ns period
    end

    always @(posedge clk125) cyc <= cyc + 1;

    // DAQ sink with random back-pressure unless stalled
    always @(posedge clk125) begin
        if (reset || stall) begin
            daq_ready <= 1'b0;
        end else begin
            daq_ready <= ($urandom_range(0, 2) != 0);
        end
    end

    // channel models and frame scoreboard
    always @(posedge clk125) begin
        logic [65:0] exp_word;
        logic [31:0] w;
        int          len;
        int          n_pay;
        if (reset) begin
            chan_done <= 2'b11;     // idle channels show done
            ch_tvalid <= 2'b00;
            ch_tlast <= 2'b00;
            for (int ch = 0; ch < 2; ch++) begin
                ch_tdata[ch] <= '0;
                wr_idx[ch] = 0;
                rel_idx[ch] = 0;
                rd_idx[ch] = 0;
                done_wait[ch] = 0;
            end
        end else begin
            n_pay = 0;
            if (acq_trigs != 2'b00) begin
                fills_seen = fills_seen + 1;
                exp_q.push_back({2'd1, 8'hA5, 32'h0, accepts_expected[23:0]}); // fills count from 1
            end
            for (int ch = 0; ch < 2; ch++) begin
                if (acq_trigs[ch]) begin
                    len = 1 + $urandom_range(0, 3);
                    for (int k = 0; k < len; k++) begin
                        w = $urandom;
                        words[ch][wr_idx[ch] % 256] = {k == len - 1, w};
                        wr_idx[ch] = wr_idx[ch] + 1;
                        exp_q.push_back({2'd0, 8'h5A, 8'(ch), 16'h0, w});
                    end
                    n_pay = n_pay + len;
                    chan_done[ch] <= 1'b0;
                    done_wait[ch] = 4 + $urandom_range(0, 8);
                end else if (done_wait[ch] > 0) begin
                    done_wait[ch] = done_wait[ch] - 1;
                    if (done_wait[ch] == 0) begin
                        chan_done[ch] <= 1'b1;
                        rel_idx[ch] = wr_idx[ch];   // packet may go out now
                    end
                end
                if (ch_tvalid[ch] && ch_tready[ch]) begin
                    rd_idx[ch] = rd_idx[ch] + 1;
                end
                // valid holds until the word moves so gaps fall only between words
                if (!ch_tvalid[ch] || ch_tready[ch]) begin
                    if (rd_idx[ch] != rel_idx[ch] && $urandom_range(0, 3) != 0) begin
                        ch_tvalid[ch] <= 1'b1;
                        ch_tlast[ch] <= words[ch][rd_idx[ch] % 256][32];
                        ch_tdata[ch] <= words[ch][rd_idx[ch] % 256][31:0];
                    end else begin
                        ch_tvalid[ch] <= 1'b0;
                    end
                end
            end
            if (acq_trigs != 2'b00) begin
                exp_q.push_back({2'd2, 8'hC3, 36'h0, 20'(n_pay + 2)}); // header and trailer too
                open_cnt = open_cnt + 1;
            end
            if (daq_valid && daq_ready) begin
                checks = checks + 1;
                if (exp_q.size() == 0) begin
                    errors = errors + 1;
                    $display("DAQ word %h arrived with no frame outstanding", daq_data);
                end else begin
                    exp_word = exp_q.pop_front();
                    if (exp_word[65:64] == 2'd2) begin
                        open_cnt = open_cnt - 1;
                    end
                    assert (daq_data == exp_word[63:0]) else begin
                        errors = errors + 1;
                        $display("[ERROR] daq_data %h expected %h", daq_data, exp_word[63:0]);
                    end
                    assert (daq_header == (exp_word[65:64] == 2'd1)) else begin
                        errors = errors + 1;
                        $display("[ERROR] daq_header %h expected %h", daq_header,
                                 exp_word[65:64] == 2'd1);
                    end
                    assert (daq_trailer == (exp_word[65:64] == 2'd2)) else begin
                        errors = errors + 1;
                        $display("[ERROR] daq_trailer %h expected %h", daq_trailer,
                                 exp_word[65:64] == 2'd2);
                    end
                end
            end
            frames_open <= open_cnt;
        end
    end

    // quiet outputs during reset and on the first cycle after it
    reset_quiet: assert property (@(posedge clk125)
        (cyc > 1 && $past(reset)) |-> (acq_trigs == 2'b00 && ch_tready == 2'b00 && !daq_valid))
        else begin
            errors = errors + 1;
            $display("[ERROR] acq_trigs %h chan_tready %h daq_valid %h during reset",
                     $sampled(acq_trigs), $sampled(ch_tready), $sampled(daq_valid));
        end

    pulse_all: assert property (@(posedge clk125) disable iff (reset)
        acq_trigs != 2'b00 |-> acq_trigs == 2'b11)
        else begin
            errors = errors + 1;
            $display("[ERROR] acq_trigs %h expected 3", $sampled(acq_trigs));
        end

    pulse_single: assert property (@(posedge clk125) disable iff (reset)
        acq_trigs != 2'b00 |=> acq_trigs == 2'b00)
        else begin
            errors = errors + 1;
            $display("[ERROR] acq_trigs %h expected 0", $sampled(acq_trigs));
        end

    // pulse follows a sampled trigger by one cycle
    pulse_after_trigger: assert property (@(posedge clk125) disable iff (reset)
        acq_trigs != 2'b00 |-> $past(trigger))
        else begin
            errors = errors + 1;
            $display("[ERROR] acq_trigs %h with trigger low", $sampled(acq_trigs));
        end

    stall_hold: assert property (@(posedge clk125) disable iff (reset)
        (daq_valid && !daq_ready) |=> (daq_valid && $stable(daq_data)))
        else begin
            errors = errors + 1;
            $display("[ERROR] daq_valid %h daq_data %h changed while stalled",
                     $sampled(daq_valid), $sampled(daq_data));
        end

    flag_shape: assert property (@(posedge clk125) disable iff (reset)
        (daq_header || daq_trailer) |-> (daq_valid && !(daq_header && daq_trailer)))
        else begin
            errors = errors + 1;
            $display("[ERROR] daq_header %h daq_trailer %h daq_valid %h",
                     $sampled(daq_header), $sampled(daq_trailer), $sampled(daq_valid));
        end

    // one trigger request and a look at the pulse that should follow
    task automatic fire_trigger(input logic expect_accept);
        logic pulsed;
        pulsed = 1'b0;
        if (expect_accept) begin
            accepts_expected = accepts_expected + 1;    // number this fill should carry
        end
        @(posedge clk125);
        trigger <= 1'b1;
        @(posedge clk125);
        trigger <= 1'b0;
        for (int n = 0; n < 2; n++) begin  // pulse due on the next cycle
            @(posedge clk125);
            if (acq_trigs != 2'b00) begin
                pulsed = 1'b1;
            end
        end
        checks = checks + 1;
        assert (pulsed == expect_accept) else begin
            errors = errors + 1;
            $display("[ERROR] acq_trigs pulse %h expected %h", pulsed, expect_accept);
        end
    endtask

    task automatic wait_channels_done();
        int n;
        n = 0;
        @(posedge clk125);
        while (chan_done != 2'b11 && n < 200) begin
            @(posedge clk125);
            n = n + 1;
        end
        if (chan_done != 2'b11) begin
            errors = errors + 1;
            $display("timeout waiting for the channel done flags");
        end
        repeat (3) @(posedge clk125);   // mask fills and the manager goes back to idle
    endtask

    task automatic drain_frames();
        int n;
        n = 0;
        @(posedge clk125);
        while (frames_open != 0 && n < 3000) begin
            @(posedge clk125);
            n = n + 1;
        end
        if (frames_open != 0) begin
            errors = errors + 1;
            $display("timeout with %0d frames still missing on the DAQ link", frames_open);
        end
    endtask

    task automatic report_test(input string name);
        tests_done = tests_done + 1;
        $display("test %0d %s finished, errors so far %0d", tests_done, name, errors);
    endtask

    task automatic finish_run();
        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        seed_val = $urandom(85106);
        repeat (16) @(posedge clk125);
        reset <= 1'b0;
        repeat (4) @(posedge clk125);
        report_test("reset");

        repeat (4) begin
            fire_trigger(1'b1);
            wait_channels_done();
        end
        drain_frames();
        report_test("accepted triggers");

        // second request lands while channels are still busy
        repeat (3) begin
            fire_trigger(1'b1);
            fire_trigger(1'b0);
            wait_channels_done();
        end
        drain_frames();
        report_test("dropped triggers");

        repeat (8) begin
            fire_trigger(1'b1);
            wait_channels_done();
        end
        drain_frames();
        report_test("back-pressure");

        // one fill held at the output and four more in the queue
        stall <= 1'b1;
        repeat (3) @(posedge clk125);
        repeat (5) begin
            fire_trigger(1'b1);
            wait_channels_done();
        end
        fire_trigger(1'b0);
        stall <= 1'b0;
        drain_frames();
        // the refused request must leave its number to the next fill
        fire_trigger(1'b1);
        wait_channels_done();
        drain_frames();
        report_test("queued fills");

        checks = checks + 1;
        assert (fills_seen == accepts_expected) else begin
            errors = errors + 1;
            $display("[ERROR] fill count %h expected %h", fills_seen, accepts_expected);
        end
        finish_run();
    end

endmodule

// File: compile.f
hw/wfd_pkg.sv
hw/trigger_manager.sv
hw/fill_num_fifo.sv
hw/channel_rx_switch.sv
hw/data_transfer_manager.sv
hw/wfd_readout_top.sv
tests/tb_wfd_readout.sv

// File: Bender.yml
package:
  name: wfd_readout

sources:
  - files:
      - hw/wfd_pkg.sv
      - hw/trigger_manager.sv
      - hw/fill_num_fifo.sv
      - hw/channel_rx_switch.sv
      - hw/data_transfer_manager.sv
      - hw/wfd_readout_top.sv
  - target: test
    files:
      - tests/tb_wfd_readout.sv

# simulation top: tb_wfd_readout
# design top: wfd_readout_top
